/* logic/backend_defs.svh */
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define DATA_W     8
`define ADDR_W     16
`define VADDR_W    12
`define VDATA_W    128
`define REG_IDX_W  5

// ------------------------------
// Memory depths
// ------------------------------
`define DMEM_DEPTH 256   // Indexed by the low byte of operand A.
`define VMEM_DEPTH 64    // Indexed by the low 6 bits of the vector address.

`endif

/* logic/backend_pkg.sv */
`default_nettype none

`include "backend_defs.svh"

package backend_pkg;

   // ------------------------------
   // Encodings
   // ------------------------------
   typedef enum logic [3:0] {
      op_nop     = 4'd0,
      op_add     = 4'd1,
      op_sub     = 4'd2,
      op_and     = 4'd3,
      op_or      = 4'd4,
      op_xor     = 4'd5,
      op_shl     = 4'd6,
      op_shr     = 4'd7,
      op_pass_b  = 4'd8,
      op_load    = 4'd9,
      op_store   = 4'd10,
      op_vload   = 4'd11,
      op_vstore  = 4'd12
   } opcode_t;

   typedef enum logic [1:0] {
      wb_alu  = 2'd0,
      wb_load = 2'd1   // Codes 2 and 3 are reserved and read as the ALU.
   } wb_sel_t;

   // ------------------------------
   // Stage bundles
   // ------------------------------
   typedef struct packed {
      logic                    valid;
      opcode_t                 opcode;
      logic [`REG_IDX_W-1:0]   rd;
      logic [`ADDR_W-1:0]      src_a;
      logic [`DATA_W-1:0]      src_b;
      logic [`VADDR_W-1:0]     vector_address;
      logic [`VDATA_W-1:0]     vector_data;
   } issue_t;

   typedef struct packed {
      logic                    wre;
      logic                    vector_wre;
      logic                    write_memory_enable;
      logic                    vector_write_enable;
      wb_sel_t                 wb_sel;
      logic [`REG_IDX_W-1:0]   rd;
      logic [`DATA_W-1:0]      alu_result;
      logic [`ADDR_W-1:0]      src_a;
      logic [`DATA_W-1:0]      src_b;
      logic [`VADDR_W-1:0]     vector_address;
      logic [`VDATA_W-1:0]     vector_data;
   } ex_mem_t;

   typedef struct packed {
      logic                    wre;
      logic                    vector_wre;
      logic [`REG_IDX_W-1:0]   rd;
      logic [`DATA_W-1:0]      data;
      logic [`VDATA_W-1:0]     vector_data;
   } wb_t;

endpackage

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "backend_defs.svh"

module execute_stage (
   input  backend_pkg::issue_t  issue,
   output backend_pkg::ex_mem_t ex
);

   logic [`DATA_W-1:0] alu_a;
   logic [`DATA_W-1:0] alu_b;
   logic [`DATA_W-1:0] alu_result;
   logic [2:0]         shift_amount;

   assign alu_a        = issue.src_a[`DATA_W-1:0];   // The ALU only sees the low byte of A.
   assign alu_b        = issue.src_b;
   assign shift_amount = alu_b[2:0];

   // ------------------------------
   // ALU
   // ------------------------------
   always_comb begin
      case (issue.opcode)
         backend_pkg::op_add:    alu_result = alu_a + alu_b;
         backend_pkg::op_sub:    alu_result = alu_a - alu_b;
         backend_pkg::op_and:    alu_result = alu_a & alu_b;
         backend_pkg::op_or:     alu_result = alu_a | alu_b;
         backend_pkg::op_xor:    alu_result = alu_a ^ alu_b;
         backend_pkg::op_shl:    alu_result = alu_a << shift_amount;
         backend_pkg::op_shr:    alu_result = alu_a >> shift_amount;
         backend_pkg::op_pass_b: alu_result = alu_b;
         default:                alu_result = '0;
      endcase
   end

   // ------------------------------
   // Decode
   // ------------------------------
   always_comb begin
      ex.wre                 = 1'b0;
      ex.vector_wre          = 1'b0;
      ex.write_memory_enable = 1'b0;
      ex.vector_write_enable = 1'b0;
      ex.wb_sel              = backend_pkg::wb_alu;
      ex.rd                  = issue.rd;
      ex.alu_result          = alu_result;
      ex.src_a               = issue.src_a;
      ex.src_b               = issue.src_b;
      ex.vector_address      = issue.vector_address;
      ex.vector_data         = issue.vector_data;

      if (issue.valid) begin   // A bubble leaves every control low.
         case (issue.opcode)
            backend_pkg::op_add,
            backend_pkg::op_sub,
            backend_pkg::op_and,
            backend_pkg::op_or,
            backend_pkg::op_xor,
            backend_pkg::op_shl,
            backend_pkg::op_shr,
            backend_pkg::op_pass_b: begin
               ex.wre = 1'b1;
            end
            backend_pkg::op_load: begin
               ex.wre    = 1'b1;
               ex.wb_sel = backend_pkg::wb_load;
            end
            backend_pkg::op_store: begin
               ex.write_memory_enable = 1'b1;
            end
            backend_pkg::op_vload: begin
               ex.vector_wre = 1'b1;
            end
            backend_pkg::op_vstore: begin
               ex.vector_write_enable = 1'b1;
            end
            default: begin
               ex.wre = 1'b0;   // No-op and unused codes do nothing.
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/execute_memory_register.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_memory_register (
   input  logic                 clk,
   input  logic                 reset,
   input  backend_pkg::ex_mem_t ex,
   output backend_pkg::ex_mem_t mem
);

   // Clearing the whole bundle keeps a stale store from reaching memory.
   always_ff @(posedge clk) begin
      if (reset) begin
         mem <= '0;
      end else begin
         mem <= ex;
      end
   end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "backend_defs.svh"

module memory_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  backend_pkg::ex_mem_t mem,
   output backend_pkg::wb_t     writeback
);

   localparam int dmem_aw = $clog2(`DMEM_DEPTH);
   localparam int vmem_aw = $clog2(`VMEM_DEPTH);

   logic [`DATA_W-1:0]    dmem [`DMEM_DEPTH];
   logic [`VDATA_W-1:0]   vmem [`VMEM_DEPTH];

   logic [dmem_aw-1:0]    dmem_index;
   logic [vmem_aw-1:0]    vmem_index;

   logic                  wre_q;
   logic                  vector_wre_q;
   logic [`REG_IDX_W-1:0] rd_q;
   backend_pkg::wb_sel_t  wb_sel_q;
   logic [`DATA_W-1:0]    alu_q;
   logic [`DATA_W-1:0]    load_q;
   logic [`VDATA_W-1:0]   vload_q;

   assign dmem_index = mem.src_a[dmem_aw-1:0];
   assign vmem_index = mem.vector_address[vmem_aw-1:0];   // Upper address bits alias.

   // ------------------------------
   // Stores
   // ------------------------------
   always_ff @(posedge clk) begin
      if (mem.write_memory_enable) begin
         dmem[dmem_index] <= mem.src_b;
      end
      if (mem.vector_write_enable) begin
         vmem[vmem_index] <= mem.vector_data;
      end
   end

   // ------------------------------
   // Registered read and controls
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wre_q        <= 1'b0;
         vector_wre_q <= 1'b0;
         rd_q         <= '0;
         wb_sel_q     <= backend_pkg::wb_alu;
         alu_q        <= '0;
         load_q       <= '0;
         vload_q      <= '0;
      end else begin
         wre_q        <= mem.wre;
         vector_wre_q <= mem.vector_wre;
         rd_q         <= mem.rd;
         wb_sel_q     <= mem.wb_sel;
         alu_q        <= mem.alu_result;
         load_q       <= dmem[dmem_index];   // Read every cycle, used only for loads.
         vload_q      <= vmem[vmem_index];
      end
   end

   // ------------------------------
   // Writeback select
   // ------------------------------
   always_comb begin
      writeback.wre         = wre_q;
      writeback.vector_wre  = vector_wre_q;
      writeback.rd          = rd_q;
      writeback.vector_data = vload_q;
      case (wb_sel_q)
         backend_pkg::wb_load: writeback.data = load_q;
         default:              writeback.data = alu_q;   // Reserved codes fall back to the ALU.
      endcase
   end

endmodule

`default_nettype wire

/* logic/backend_top.sv */
`timescale 1ns/1ns
`default_nettype none

module backend_top (
   input  logic                clk,
   input  logic                reset,
   input  backend_pkg::issue_t issue,
   output backend_pkg::wb_t    writeback
);

   backend_pkg::ex_mem_t ex_bus;
   backend_pkg::ex_mem_t mem_bus;

   execute_stage execute_i (
      .issue (issue),
      .ex    (ex_bus)
   );

   execute_memory_register ex_mem_reg_i (
      .clk   (clk),
      .reset (reset),
      .ex    (ex_bus),
      .mem   (mem_bus)
   );

   memory_stage memory_i (
      .clk       (clk),
      .reset     (reset),
      .mem       (mem_bus),
      .writeback (writeback)
   );

endmodule

`default_nettype wire

/* bench/backend_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module backend_assert (
   input logic                clk,
   input logic                reset,
   input backend_pkg::issue_t issue,
   input backend_pkg::wb_t    writeback
);

   logic writes_scalar;

   assign writes_scalar = issue.valid && (issue.opcode inside {
      backend_pkg::op_add, backend_pkg::op_sub, backend_pkg::op_and, backend_pkg::op_or,
      backend_pkg::op_xor, backend_pkg::op_shl, backend_pkg::op_shr, backend_pkg::op_pass_b,
      backend_pkg::op_load});

   // ------------------------------
   // Writeback enables
   // ------------------------------
   one_port_at_a_time: assert property (@(posedge clk) disable iff (reset)
      !(writeback.wre && writeback.vector_wre))
      else $error("Scalar and vector writeback enables are high together.");

   quiet_in_reset: assert property (@(posedge clk)
      reset |=> (!writeback.wre && !writeback.vector_wre))
      else $error("A writeback enable is high during reset.");

   quiet_after_reset: assert property (@(posedge clk)
      $fell(reset) |=> (!writeback.wre && !writeback.vector_wre))
      else $error("A writeback enable is high in the cycle after reset.");

   // Fixed latency of two edges from issue to scalar writeback.
   scalar_latency: assert property (@(posedge clk) disable iff (reset)
      writeback.wre == $past(writes_scalar, 2))
      else $error("Scalar writeback enable does not follow the issue two edges earlier.");

endmodule

`default_nettype wire

/* bench/backend_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "backend_defs.svh"

module backend_tb;

   localparam int period       = 40;
   localparam int random_count = 200;
   localparam int vmem_aw      = $clog2(`VMEM_DEPTH);

   typedef logic [`VDATA_W-1:0] value_t;

   typedef struct packed {
      backend_pkg::issue_t issue;
      backend_pkg::wb_t    result;
   } row_t;

   typedef struct packed {
      backend_pkg::wb_t wb;
      logic             data_known;
      logic             vdata_known;
   } expect_t;

   localparam value_t vec_one = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
   localparam value_t vec_two = 128'hdead_beef_0000_ffff_a5a5_5a5a_1357_9bdf;
   localparam value_t zero_v  = '0;

   logic                clk = 1'b0;
   logic                reset;
   backend_pkg::issue_t issue;
   backend_pkg::wb_t    writeback;

   row_t    rows_q [$];
   expect_t pending_q [$];   // At most two instructions are in flight.

   logic [`DATA_W-1:0] model_dmem [`DMEM_DEPTH];
   logic               dmem_known [`DMEM_DEPTH];
   value_t             model_vmem [`VMEM_DEPTH];
   logic               vmem_known [`VMEM_DEPTH];

   backend_top dut_i (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .writeback (writeback)
   );

   bind backend_top backend_assert assert_i (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .writeback (writeback)
   );

   always #(period / 2) clk = ~clk;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [`DATA_W-1:0] alu_ref(input backend_pkg::opcode_t op,
                                                  input logic [`DATA_W-1:0] a,
                                                  input logic [`DATA_W-1:0] b);
      case (op)
         backend_pkg::op_add: return a + b;
         backend_pkg::op_sub: return a - b;
         backend_pkg::op_and: return a & b;
         backend_pkg::op_or:  return a | b;
         backend_pkg::op_xor: return a ^ b;
         backend_pkg::op_shl: return a << b[2:0];
         backend_pkg::op_shr: return a >> b[2:0];
         default:             return b;
      endcase
   endfunction

   // Applies one issue in program order and returns what its writeback must show.
   task automatic apply_model(input backend_pkg::issue_t i, output expect_t e);
      logic [`DATA_W-1:0] a;
      logic [vmem_aw-1:0] vi;
      a  = i.src_a[`DATA_W-1:0];
      vi = i.vector_address[vmem_aw-1:0];
      e  = '0;
      if (i.valid) begin
         case (i.opcode)
            backend_pkg::op_add, backend_pkg::op_sub, backend_pkg::op_and,
            backend_pkg::op_or, backend_pkg::op_xor, backend_pkg::op_shl,
            backend_pkg::op_shr, backend_pkg::op_pass_b: begin
               e.wb.wre     = 1'b1;
               e.wb.rd      = i.rd;
               e.wb.data    = alu_ref(i.opcode, a, i.src_b);
               e.data_known = 1'b1;
            end
            backend_pkg::op_load: begin
               e.wb.wre     = 1'b1;
               e.wb.rd      = i.rd;
               e.wb.data    = model_dmem[a];
               e.data_known = dmem_known[a];   // Untouched bytes are not checked.
            end
            backend_pkg::op_store: begin
               model_dmem[a] = i.src_b;
               dmem_known[a] = 1'b1;
            end
            backend_pkg::op_vload: begin
               e.wb.vector_wre  = 1'b1;
               e.wb.rd          = i.rd;
               e.wb.vector_data = model_vmem[vi];
               e.vdata_known    = vmem_known[vi];
            end
            backend_pkg::op_vstore: begin
               model_vmem[vi] = i.vector_data;
               vmem_known[vi] = 1'b1;
            end
            default: begin
            end
         endcase
      end
   endtask

   // ------------------------------
   // Stimulus and checks
   // ------------------------------
   task automatic add_row(input logic valid, input backend_pkg::opcode_t op,
                          input logic [`REG_IDX_W-1:0] rd, input logic [`ADDR_W-1:0] a,
                          input logic [`DATA_W-1:0] b, input logic [`VADDR_W-1:0] va,
                          input value_t vd, input logic wre, input logic vector_wre,
                          input logic [`DATA_W-1:0] data, input value_t vdata);
      row_t r;
      r.issue.valid              = valid;
      r.issue.opcode             = op;
      r.issue.rd                 = rd;
      r.issue.src_a              = a;
      r.issue.src_b              = b;
      r.issue.vector_address     = va;
      r.issue.vector_data        = vd;
      r.result.wre               = wre;
      r.result.vector_wre        = vector_wre;
      r.result.rd                = rd;
      r.result.data              = data;
      r.result.vector_data       = vdata;
      rows_q.push_back(r);
   endtask

   task automatic build_table();
      // Bubbles carrying store codes must not write or raise an enable.
      add_row(1'b0, backend_pkg::op_store, 5'd0, 16'h0030, 8'hee, 12'h000, zero_v,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b0, backend_pkg::op_vstore, 5'd0, 16'h0000, 8'h00, 12'h007, vec_one,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b0, backend_pkg::op_add, 5'd3, 16'h0001, 8'h01, 12'h000, zero_v,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_add, 5'd1, 16'h1234, 8'h56, 12'h000, zero_v,
              1'b1, 1'b0, 8'h8a, zero_v);
      add_row(1'b1, backend_pkg::op_sub, 5'd2, 16'h0010, 8'h20, 12'h000, zero_v,
              1'b1, 1'b0, 8'hf0, zero_v);
      add_row(1'b1, backend_pkg::op_and, 5'd3, 16'hfff0, 8'h3c, 12'h000, zero_v,
              1'b1, 1'b0, 8'h30, zero_v);
      add_row(1'b1, backend_pkg::op_or, 5'd4, 16'h00a0, 8'h05, 12'h000, zero_v,
              1'b1, 1'b0, 8'ha5, zero_v);
      add_row(1'b1, backend_pkg::op_xor, 5'd5, 16'h00ff, 8'h0f, 12'h000, zero_v,
              1'b1, 1'b0, 8'hf0, zero_v);
      add_row(1'b1, backend_pkg::op_shl, 5'd6, 16'h0081, 8'h09, 12'h000, zero_v,
              1'b1, 1'b0, 8'h02, zero_v);
      add_row(1'b1, backend_pkg::op_shr, 5'd7, 16'h0080, 8'hff, 12'h000, zero_v,
              1'b1, 1'b0, 8'h01, zero_v);
      add_row(1'b1, backend_pkg::op_pass_b, 5'd8, 16'h5555, 8'hc3, 12'h000, zero_v,
              1'b1, 1'b0, 8'hc3, zero_v);
      add_row(1'b1, backend_pkg::op_add, 5'd9, 16'h00ff, 8'h02, 12'h000, zero_v,
              1'b1, 1'b0, 8'h01, zero_v);
      // Store then load on the next cycle.
      add_row(1'b1, backend_pkg::op_store, 5'd0, 16'h0042, 8'h7e, 12'h000, zero_v,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_load, 5'd10, 16'h0042, 8'h00, 12'h000, zero_v,
              1'b1, 1'b0, 8'h7e, zero_v);
      add_row(1'b1, backend_pkg::op_store, 5'd0, 16'h0043, 8'h19, 12'h000, zero_v,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_load, 5'd11, 16'hab43, 8'h00, 12'h000, zero_v,
              1'b1, 1'b0, 8'h19, zero_v);
      // A bubble store to a written byte leaves the old value in place.
      add_row(1'b0, backend_pkg::op_store, 5'd0, 16'h0042, 8'hee, 12'h000, zero_v,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_load, 5'd14, 16'h0042, 8'h00, 12'h000, zero_v,
              1'b1, 1'b0, 8'h7e, zero_v);
      // Vector store then load, the second pair aliasing above bit 5.
      add_row(1'b1, backend_pkg::op_vstore, 5'd0, 16'h0000, 8'h00, 12'h005, vec_one,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_vload, 5'd12, 16'h0000, 8'h00, 12'h005, zero_v,
              1'b0, 1'b1, 8'h00, vec_one);
      add_row(1'b1, backend_pkg::op_vstore, 5'd0, 16'h0000, 8'h00, 12'h013, vec_two,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_vload, 5'd13, 16'h0000, 8'h00, 12'hfd3, zero_v,
              1'b0, 1'b1, 8'h00, vec_two);
      // A bubble vector store leaves the entry alone.
      add_row(1'b0, backend_pkg::op_vstore, 5'd0, 16'h0000, 8'h00, 12'h005, vec_two,
              1'b0, 1'b0, 8'h00, zero_v);
      add_row(1'b1, backend_pkg::op_vload, 5'd15, 16'h0000, 8'h00, 12'h005, zero_v,
              1'b0, 1'b1, 8'h00, vec_one);
   endtask

   function automatic backend_pkg::issue_t random_issue();
      backend_pkg::issue_t i;
      i.valid          = ($urandom_range(0, 7) != 0);
      i.opcode         = backend_pkg::opcode_t'(4'($urandom_range(0, 12)));
      i.rd             = 5'($urandom);
      i.src_a          = {8'($urandom), 4'h4, 4'($urandom)};   // Small window so loads hit stores.
      i.src_b          = 8'($urandom);
      i.vector_address = {6'($urandom), 3'b000, 3'($urandom)};
      i.vector_data    = {$urandom, $urandom, $urandom, $urandom};
      return i;
   endfunction

   task automatic check_value(input string name, input value_t actual, input value_t expected);
      if (actual !== expected) begin
         $display("Error: %s is %h, expected %h", name, actual, expected);
         $display("test failed");
         $fatal(1, "Mismatch on %s.", name);
      end
   endtask

   task automatic compare_writeback(input expect_t e);
      check_value("writeback.wre", value_t'(writeback.wre), value_t'(e.wb.wre));
      check_value("writeback.vector_wre", value_t'(writeback.vector_wre),
                  value_t'(e.wb.vector_wre));
      if (e.wb.wre || e.wb.vector_wre) begin
         check_value("writeback.rd", value_t'(writeback.rd), value_t'(e.wb.rd));
      end
      if (e.wb.wre && e.data_known) begin
         check_value("writeback.data", value_t'(writeback.data), value_t'(e.wb.data));
      end
      if (e.wb.vector_wre && e.vdata_known) begin
         check_value("writeback.vector_data", writeback.vector_data, e.wb.vector_data);
      end
   endtask

   // Writeback seen at a falling edge belongs to the issue driven two falling edges earlier.
   task automatic issue_and_check(input backend_pkg::issue_t next, input expect_t e);
      expect_t oldest;
      @(negedge clk);
      if (pending_q.size() == 2) begin
         oldest = pending_q.pop_front();
         compare_writeback(oldest);
      end
      issue = next;
      pending_q.push_back(e);
   endtask

   task automatic run_watchdog();
      #((rows_q.size() + random_count + 20) * period);
      $display("test failed");
      $fatal(1, "Timeout: the writeback checks did not finish in time.");
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      backend_pkg::issue_t next;
      expect_t             e;
      expect_t             last;
      row_t                r;

      reset = 1'b1;
      issue = '0;
      void'($urandom(32'h592e));
      foreach (dmem_known[k]) begin
         dmem_known[k] = 1'b0;
      end
      foreach (vmem_known[k]) begin
         vmem_known[k] = 1'b0;
      end
      build_table();
      fork
         run_watchdog();
      join_none

      repeat (10) @(negedge clk);
      reset = 1'b0;
      check_value("writeback.wre", value_t'(writeback.wre), zero_v);
      check_value("writeback.vector_wre", value_t'(writeback.vector_wre), zero_v);

      foreach (rows_q[k]) begin
         r = rows_q[k];
         apply_model(r.issue, e);   // Keeps the model memories in step.
         e.wb          = r.result;
         e.data_known  = r.result.wre;
         e.vdata_known = r.result.vector_wre;
         issue_and_check(r.issue, e);
      end

      repeat (random_count) begin
         next = random_issue();
         apply_model(next, e);
         issue_and_check(next, e);
      end

      while (pending_q.size() > 0) begin
         @(negedge clk);
         last = pending_q.pop_front();
         compare_writeback(last);
         issue = '0;
      end

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/backend_pkg.sv
logic/execute_stage.sv
logic/execute_memory_register.sv
logic/memory_stage.sv
logic/backend_top.sv
bench/backend_assert.sv
bench/backend_tb.sv

/* Makefile */
TOP = backend_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
